// File: rtl/fabric_pkg.sv
// tile ids pack column over row in 4-bit fields; single-flit requests only; grid is fixed at 3x3
`default_nettype none

package fabric_pkg;

    //====================
    // mesh constants
    //====================
    localparam int fab_cols   = 3;  // columns 1..fab_cols, numbered eastward
    localparam int fab_rows   = 3;  // rows 1..fab_rows, numbered southward
    localparam int fifo_depth = 2;  // entries per router input queue
    localparam int fifo_ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);  // count reaches fifo_depth

    //====================
    // link types
    //====================
    typedef struct packed {
        logic [3:0] col;  // upper nibble
        logic [3:0] row;  // lower nibble
    } t_tile_id;

    typedef struct packed {
        t_tile_id    target;  // destination tile
        t_tile_id    source;  // injecting tile
        logic [7:0]  tag;
        logic [31:0] data;
    } t_tile_trans;  // 56 bits on every link

    typedef logic t_fab_ready;  // receiving queue has room this cycle

    // router port index, also the arbiter request bit
    typedef enum logic [2:0] {
        port_north = 3'd0,
        port_east  = 3'd1,
        port_south = 3'd2,
        port_west  = 3'd3,
        port_local = 3'd4
    } t_port;

endpackage

`default_nettype wire

// File: rtl/fabric_fifo.sv
// no bypass so a write shows at the head one cycle later; push when full and pop when empty are ignored
`default_nettype none

module fabric_fifo (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    push,
    input  fabric_pkg::t_tile_trans push_req,
    input  logic                    pop,
    output fabric_pkg::t_tile_trans head,
    output logic                    empty,
    output logic                    full
);
    import fabric_pkg::*;

    t_tile_trans           mem [fifo_depth];  // storage
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;             // entries held
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && !full;   // drop writes into a full queue
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == fifo_cnt_w'(fifo_depth));
    assign head    = mem[rd_ptr];     // oldest entry

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    // pointers wrap at fifo_depth
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + fifo_cnt_w'(do_push) - fifo_cnt_w'(do_pop);
        end
    end

endmodule

`default_nettype wire

// File: rtl/fabric_rr_arb.sv
// five requesters; a grant that stalls stays locked until advance so the output holds steady
`default_nettype none

module fabric_rr_arb (
    input  logic       clk,
    input  logic       reset,
    input  logic [4:0] req,      // one bit per input port
    input  logic       advance,  // granted transfer completes this cycle
    output logic [4:0] grant     // one-hot, zero when idle
);
    logic [2:0] prio;      // input with top priority
    logic [2:0] pick;      // fresh winner from req
    logic       pick_any;
    logic       locked;    // grant stalled on the last edge
    logic [2:0] held;      // winner kept while locked
    logic [2:0] winner;

    // scan from prio downward in offset, lowest offset with a request wins
    always_comb begin
        pick     = prio;
        pick_any = 1'b0;
        for (int i = 4; i >= 0; i--) begin
            int k;
            k = int'(prio) + i;
            if (k >= 5) begin
                k = k - 5;  // wrap around the five ports
            end
            if (req[k]) begin
                pick     = 3'(k);
                pick_any = 1'b1;
            end
        end
    end

    assign winner = locked ? held : pick;
    assign grant  = (locked || pick_any) ? (5'b00001 << winner) : 5'b00000;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio   <= '0;
            locked <= 1'b0;
            held   <= '0;
        end else begin
            locked <= (|grant) && !advance;  // receiver stalled, keep this winner
            held   <= winner;
            if ((|grant) && advance) begin
                prio <= (winner == 3'd4) ? 3'd0 : winner + 3'd1;  // rotate past winner
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/big_core_tile.sv
// xy routing only; boundary links must be strapped idle; local targets outside 1..3 are dropped
`default_nettype none

module big_core_tile (
    input  logic                    clk,
    input  logic                    reset,
    input  fabric_pkg::t_tile_id    local_tile_id,
    // north link
    input  logic                    in_north_req_valid,
    input  fabric_pkg::t_tile_trans in_north_req,
    output fabric_pkg::t_fab_ready  out_north_ready,
    output logic                    out_north_req_valid,
    output fabric_pkg::t_tile_trans out_north_req,
    input  fabric_pkg::t_fab_ready  in_north_ready,
    // east link
    input  logic                    in_east_req_valid,
    input  fabric_pkg::t_tile_trans in_east_req,
    output fabric_pkg::t_fab_ready  out_east_ready,
    output logic                    out_east_req_valid,
    output fabric_pkg::t_tile_trans out_east_req,
    input  fabric_pkg::t_fab_ready  in_east_ready,
    // west link
    input  logic                    in_west_req_valid,
    input  fabric_pkg::t_tile_trans in_west_req,
    output fabric_pkg::t_fab_ready  out_west_ready,
    output logic                    out_west_req_valid,
    output fabric_pkg::t_tile_trans out_west_req,
    input  fabric_pkg::t_fab_ready  in_west_ready,
    // south link
    input  logic                    in_south_req_valid,
    input  fabric_pkg::t_tile_trans in_south_req,
    output fabric_pkg::t_fab_ready  out_south_ready,
    output logic                    out_south_req_valid,
    output fabric_pkg::t_tile_trans out_south_req,
    input  fabric_pkg::t_fab_ready  in_south_ready,
    // local injection and ejection
    input  logic                    local_req_valid,
    input  fabric_pkg::t_tile_trans local_req,
    output fabric_pkg::t_fab_ready  local_req_ready,
    output logic                    local_rsp_valid,
    output fabric_pkg::t_tile_trans local_rsp,
    input  logic                    local_rsp_ready,
    output logic                    local_drop
);
    import fabric_pkg::*;

    logic        [4:0]      in_valid;   // per input port, local gated by range check
    t_tile_trans [4:0]      in_req;
    logic        [4:0]      q_pop;
    logic        [4:0]      q_empty;
    logic        [4:0]      q_full;
    t_tile_trans [4:0]      q_head;
    t_port                  route [5];  // output wanted by each queue head
    logic        [4:0]      out_ready;  // downstream ready per output
    logic        [4:0]      out_valid;
    t_tile_trans [4:0]      out_req;
    logic        [4:0]      out_fire;   // handshake per output
    logic        [4:0][4:0] arb_req;    // [output][input]
    logic        [4:0][4:0] arb_grant;
    logic                   local_in_grid;
    logic                   drop_q;

    // column first, then row; rows grow southward
    function automatic t_port xy_route(input t_tile_id tgt, input t_tile_id here);
        if (tgt.col > here.col) begin
            return port_east;
        end else if (tgt.col < here.col) begin
            return port_west;
        end else if (tgt.row > here.row) begin
            return port_south;
        end else if (tgt.row < here.row) begin
            return port_north;
        end
        return port_local;
    endfunction

    //====================
    // input side
    //====================
    assign local_in_grid = (local_req.target.col != '0) && (local_req.target.col <= 4'(fab_cols))
                        && (local_req.target.row != '0) && (local_req.target.row <= 4'(fab_rows));

    // index order follows t_port
    assign in_valid = {local_req_valid && local_in_grid, in_west_req_valid, in_south_req_valid,
                       in_east_req_valid, in_north_req_valid};
    assign in_req   = {local_req, in_west_req, in_south_req, in_east_req, in_north_req};

    assign out_north_ready = !q_full[port_north];
    assign out_east_ready  = !q_full[port_east];
    assign out_south_ready = !q_full[port_south];
    assign out_west_ready  = !q_full[port_west];
    assign local_req_ready = !q_full[port_local];  // also taken for out-of-grid requests

    // out-of-grid request consumed here, pulse one cycle on
    always_ff @(posedge clk) begin
        if (reset) begin
            drop_q <= 1'b0;
        end else begin
            drop_q <= local_req_valid && local_req_ready && !local_in_grid;
        end
    end
    assign local_drop = drop_q;

    //====================
    // queues and arbiters
    //====================
    for (genvar p = 0; p < 5; p++) begin : g_port
        fabric_fifo i_fifo (
            .clk      (clk),
            .reset    (reset),
            .push     (in_valid[p]),
            .push_req (in_req[p]),
            .pop      (q_pop[p]),
            .head     (q_head[p]),
            .empty    (q_empty[p]),
            .full     (q_full[p])
        );

        assign route[p] = xy_route(q_head[p].target, local_tile_id);

        fabric_rr_arb i_arb (
            .clk     (clk),
            .reset   (reset),
            .req     (arb_req[p]),    // heads bound for output p
            .advance (out_fire[p]),
            .grant   (arb_grant[p])
        );

        assign out_valid[p] = |arb_grant[p];
        assign out_fire[p]  = out_valid[p] && out_ready[p];
    end

    always_comb begin
        for (int o = 0; o < 5; o++) begin
            for (int i = 0; i < 5; i++) begin
                arb_req[o][i] = !q_empty[i] && (route[i] == t_port'(o));
            end
        end
    end

    // grant selects the head; winner pops on the handshake edge
    always_comb begin
        out_req = '0;
        q_pop   = '0;
        for (int o = 0; o < 5; o++) begin
            for (int i = 0; i < 5; i++) begin
                if (arb_grant[o][i]) begin
                    out_req[o] = q_head[i];
                    q_pop[i]   = out_fire[o];  // a head wants one output only
                end
            end
        end
    end

    //====================
    // output side
    //====================
    assign out_ready = {local_rsp_ready, in_west_ready, in_south_ready,
                        in_east_ready, in_north_ready};

    assign out_north_req_valid = out_valid[port_north];
    assign out_north_req       = out_req[port_north];
    assign out_east_req_valid  = out_valid[port_east];
    assign out_east_req        = out_req[port_east];
    assign out_south_req_valid = out_valid[port_south];
    assign out_south_req       = out_req[port_south];
    assign out_west_req_valid  = out_valid[port_west];
    assign out_west_req        = out_req[port_west];
    assign local_rsp_valid     = out_valid[port_local];  // ejection
    assign local_rsp           = out_req[port_local];

endmodule

`default_nettype wire

// File: rtl/fabric_big_cores.sv
// 3x3 grid with tile [1,1] top-left; edge links are strapped to zero so targets must be in 1..3
`default_nettype none

module fabric_big_cores (
    input  logic                                                       clk,
    input  logic                                                       reset,
    input  logic [fabric_pkg::fab_cols:1][fabric_pkg::fab_rows:1]      tile_req_valid,
    input  fabric_pkg::t_tile_trans
                 [fabric_pkg::fab_cols:1][fabric_pkg::fab_rows:1]      tile_req,
    output logic [fabric_pkg::fab_cols:1][fabric_pkg::fab_rows:1]      tile_req_ready,
    output logic [fabric_pkg::fab_cols:1][fabric_pkg::fab_rows:1]      tile_rsp_valid,
    output fabric_pkg::t_tile_trans
                 [fabric_pkg::fab_cols:1][fabric_pkg::fab_rows:1]      tile_rsp,
    input  logic [fabric_pkg::fab_cols:1][fabric_pkg::fab_rows:1]      tile_rsp_ready,
    output logic [fabric_pkg::fab_cols:1][fabric_pkg::fab_rows:1]      tile_drop
);
    import fabric_pkg::*;

    // inputs exist for real tiles only
    logic        [fab_cols:1][fab_rows:1] in_north_req_valid, in_east_req_valid;
    logic        [fab_cols:1][fab_rows:1] in_west_req_valid, in_south_req_valid;
    t_tile_trans [fab_cols:1][fab_rows:1] in_north_req, in_east_req, in_west_req, in_south_req;
    t_fab_ready  [fab_cols:1][fab_rows:1] in_north_ready, in_east_ready;
    t_fab_ready  [fab_cols:1][fab_rows:1] in_west_ready, in_south_ready;
    // outputs include the strapped ring at index 0 and fab_cols+1
    logic        [fab_cols+1:0][fab_rows+1:0] out_north_req_valid, out_east_req_valid;
    logic        [fab_cols+1:0][fab_rows+1:0] out_west_req_valid, out_south_req_valid;
    t_tile_trans [fab_cols+1:0][fab_rows+1:0] out_north_req, out_east_req;
    t_tile_trans [fab_cols+1:0][fab_rows+1:0] out_west_req, out_south_req;
    t_fab_ready  [fab_cols+1:0][fab_rows+1:0] out_north_ready, out_east_ready;
    t_fab_ready  [fab_cols+1:0][fab_rows+1:0] out_west_ready, out_south_ready;
    t_tile_id    [fab_cols:1][fab_rows:1]     local_tile_id;

    //====================
    // tile grid
    //====================
    for (genvar gcol = 1; gcol <= fab_cols; gcol++) begin : g_col
        for (genvar grow = 1; grow <= fab_rows; grow++) begin : g_row
            assign local_tile_id[gcol][grow] = t_tile_id'({4'(gcol), 4'(grow)});

            // south input from the tile below where row fab_rows+1 is the strap
            assign in_south_req_valid[gcol][grow] = out_north_req_valid[gcol][grow+1];
            assign in_south_req[gcol][grow]       = out_north_req[gcol][grow+1];
            assign in_south_ready[gcol][grow]     = out_north_ready[gcol][grow+1];
            assign in_north_req_valid[gcol][grow] = out_south_req_valid[gcol][grow-1];
            assign in_north_req[gcol][grow]       = out_south_req[gcol][grow-1];
            assign in_north_ready[gcol][grow]     = out_south_ready[gcol][grow-1];
            // east input from the next column over
            assign in_east_req_valid[gcol][grow]  = out_west_req_valid[gcol+1][grow];
            assign in_east_req[gcol][grow]        = out_west_req[gcol+1][grow];
            assign in_east_ready[gcol][grow]      = out_west_ready[gcol+1][grow];
            assign in_west_req_valid[gcol][grow]  = out_east_req_valid[gcol-1][grow];
            assign in_west_req[gcol][grow]        = out_east_req[gcol-1][grow];
            assign in_west_ready[gcol][grow]      = out_east_ready[gcol-1][grow];

            big_core_tile i_tile (
                .clk                 (clk),
                .reset               (reset),
                .local_tile_id       (local_tile_id[gcol][grow]),
                .in_north_req_valid  (in_north_req_valid[gcol][grow]),
                .in_north_req        (in_north_req[gcol][grow]),
                .out_north_ready     (out_north_ready[gcol][grow]),
                .out_north_req_valid (out_north_req_valid[gcol][grow]),
                .out_north_req       (out_north_req[gcol][grow]),
                .in_north_ready      (in_north_ready[gcol][grow]),
                .in_east_req_valid   (in_east_req_valid[gcol][grow]),
                .in_east_req         (in_east_req[gcol][grow]),
                .out_east_ready      (out_east_ready[gcol][grow]),
                .out_east_req_valid  (out_east_req_valid[gcol][grow]),
                .out_east_req        (out_east_req[gcol][grow]),
                .in_east_ready       (in_east_ready[gcol][grow]),
                .in_west_req_valid   (in_west_req_valid[gcol][grow]),
                .in_west_req         (in_west_req[gcol][grow]),
                .out_west_ready      (out_west_ready[gcol][grow]),
                .out_west_req_valid  (out_west_req_valid[gcol][grow]),
                .out_west_req        (out_west_req[gcol][grow]),
                .in_west_ready       (in_west_ready[gcol][grow]),
                .in_south_req_valid  (in_south_req_valid[gcol][grow]),
                .in_south_req        (in_south_req[gcol][grow]),
                .out_south_ready     (out_south_ready[gcol][grow]),
                .out_south_req_valid (out_south_req_valid[gcol][grow]),
                .out_south_req       (out_south_req[gcol][grow]),
                .in_south_ready      (in_south_ready[gcol][grow]),
                .local_req_valid     (tile_req_valid[gcol][grow]),
                .local_req           (tile_req[gcol][grow]),
                .local_req_ready     (tile_req_ready[gcol][grow]),
                .local_rsp_valid     (tile_rsp_valid[gcol][grow]),
                .local_rsp           (tile_rsp[gcol][grow]),
                .local_rsp_ready     (tile_rsp_ready[gcol][grow]),
                .local_drop          (tile_drop[gcol][grow])
            );
        end
    end

    //====================
    // boundary straps
    //====================
    // ring never offers a request and never accepts one
    for (genvar gcol = 0; gcol <= fab_cols + 1; gcol++) begin : g_strap_col
        for (genvar grow = 0; grow <= fab_rows + 1; grow++) begin : g_strap_row
            if ((gcol == 0) || (gcol == fab_cols + 1)
                || (grow == 0) || (grow == fab_rows + 1)) begin : g_edge
                assign out_north_req_valid[gcol][grow] = 1'b0;
                assign out_east_req_valid[gcol][grow]  = 1'b0;
                assign out_south_req_valid[gcol][grow] = 1'b0;
                assign out_west_req_valid[gcol][grow]  = 1'b0;
                assign out_north_req[gcol][grow]       = '0;
                assign out_east_req[gcol][grow]        = '0;
                assign out_south_req[gcol][grow]       = '0;
                assign out_west_req[gcol][grow]        = '0;
                assign out_north_ready[gcol][grow]     = 1'b0;
                assign out_east_ready[gcol][grow]      = 1'b0;
                assign out_south_ready[gcol][grow]     = 1'b0;
                assign out_west_ready[gcol][grow]      = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/fabric_big_cores_assert.sv
// bound into every big_core_tile; port order of the vectors follows t_port
`default_nettype none

module fabric_big_cores_assert (
    input logic                          clk,
    input logic                          reset,
    input fabric_pkg::t_tile_id          local_tile_id,
    input logic [4:0]                    out_valid,
    input fabric_pkg::t_tile_trans [4:0] out_req,
    input logic [4:0]                    out_ready,
    input logic [4:0]                    q_empty,
    input logic [4:0]                    q_pop,
    input logic                          local_rsp_valid,
    input fabric_pkg::t_tile_trans       local_rsp
);
    timeunit 1ns;
    timeprecision 1ps;
    import fabric_pkg::*;

    //====================
    // per port
    //====================
    for (genvar p = 0; p < 5; p++) begin : g_port
        // stalled output keeps valid and request
        assert property (@(posedge clk) disable iff (reset)
            out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_req[p]))
            else $error("output %0d changed while stalled", p);

        // a granted head always holds an entry, even under a locked grant
        assert property (@(posedge clk) disable iff (reset)
            q_pop[p] |-> !q_empty[p])
            else $error("queue %0d popped while empty", p);
    end

    // ejection only at the target tile
    assert property (@(posedge clk) disable iff (reset)
        local_rsp_valid |-> local_rsp.target == local_tile_id)
        else $error("misrouted ejection at tile %h", local_tile_id);

endmodule

`default_nettype wire

// File: dv/fabric_big_cores_tb.sv
// drives the fabric through its local ports; one injector at a time, contention only in flight
`default_nettype none

module fabric_big_cores_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fabric_pkg::*;

    typedef struct {
        string       name;
        int          sc, sr, tc, tr;  // source and target tile
        logic [7:0]  tag;
        logic [31:0] data;
        bit          stall, lone, drop;
    } t_row;

    logic clk;
    logic reset;
    logic        [fab_cols:1][fab_rows:1] tile_req_valid, tile_req_ready;
    t_tile_trans [fab_cols:1][fab_rows:1] tile_req, tile_rsp;
    logic        [fab_cols:1][fab_rows:1] tile_rsp_valid, tile_rsp_ready, tile_drop;

    t_row        rows[$];
    t_tile_trans exp_q[9][9][$];    // [source][target] expected requests
    int          exp_row[9][9][$];  // row index of each expected request
    time         exp_t[9][9][$];    // injection handshake time
    int          drop_rows[9][$];   // pending drops per source
    bit          stall_en[9];
    logic [31:0] lfsr = 32'hc8e7_0a63;
    int          outstanding = 0;
    int          errors = 0;
    int          n_deliv = 0, n_drops = 0, exp_deliv = 0, exp_drops = 0;
    int          saw_bp = 0;        // tile_req_ready seen low under load

    fabric_big_cores i_dut (.*);

    bind big_core_tile fabric_big_cores_assert i_assert (
        .clk(clk), .reset(reset), .local_tile_id(local_tile_id),
        .out_valid(out_valid), .out_req(out_req), .out_ready(out_ready),
        .q_empty(q_empty), .q_pop(q_pop),
        .local_rsp_valid(local_rsp_valid), .local_rsp(local_rsp)
    );

    //====================
    // helpers
    //====================
    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois form with taps 32 22 2 1
    endfunction

    function automatic int tile_idx(input int c, input int r);
        return (c - 1) * 3 + (r - 1);
    endfunction

    function automatic void add_row(string name, int sc, int sr, int tc, int tr,
                                    logic [7:0] tag, bit stall, bit lone, bit drop);
        t_row row;
        row.name = name;
        row.sc = sc;
        row.sr = sr;
        row.tc = tc;
        row.tr = tr;
        row.tag = tag;
        row.data = 32'h5a00_0000 | (32'(rows.size()) << 8) | 32'(tag);
        row.stall = stall;
        row.lone = lone;
        row.drop = drop;
        rows.push_back(row);
    endfunction

    task automatic check_trans(string name, t_tile_trans exp, t_tile_trans act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            errors++;
            $display("error %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bits(string name, logic [fab_cols:1][fab_rows:1] exp,
                              logic [fab_cols:1][fab_rows:1] act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b actual %b", name, exp, act);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    //====================
    // ejection and drop monitor
    //====================
    always @(posedge clk) begin
        int          s;
        int          k;
        int          lat;
        bit          b0;
        bit          b1;
        t_tile_trans got;
        if (!reset) begin
            for (int c = 1; c <= 3; c++) begin
                for (int r = 1; r <= 3; r++) begin
                    if (tile_req_valid[c][r] && !tile_req_ready[c][r]) saw_bp = 1;
                    if (tile_rsp_valid[c][r] && tile_rsp_ready[c][r]) begin
                        got = tile_rsp[c][r];
                        s = tile_idx(got.source.col, got.source.row);
                        if (s < 0 || s > 8 || got.source.col > 3 || got.source.row > 3
                            || exp_q[s][tile_idx(c, r)].size() == 0) begin
                            errors++;
                            $display("unexpected request ejected at tile (%0d,%0d): %h",
                                     c, r, got);
                        end else begin
                            k = exp_row[s][tile_idx(c, r)].pop_front();
                            lat = int'(($time - exp_t[s][tile_idx(c, r)].pop_front()) / 100);
                            check_trans(rows[k].name, exp_q[s][tile_idx(c, r)].pop_front(), got);
                            if (rows[k].lone) begin  // manhattan distance plus one
                                check_count({rows[k].name, " latency"}, 1 + ((rows[k].sc > c) ?
                                    rows[k].sc - c : c - rows[k].sc) + ((rows[k].sr > r) ?
                                    rows[k].sr - r : r - rows[k].sr), lat);
                            end
                            $display("%s: delivered at (%0d,%0d) after %0d cycles",
                                     rows[k].name, c, r, lat);
                            n_deliv++;
                            outstanding--;
                        end
                    end
                    if (tile_drop[c][r]) begin
                        if (drop_rows[tile_idx(c, r)].size() == 0) begin
                            errors++;
                            $display("unexpected drop pulse at tile (%0d,%0d)", c, r);
                        end else begin
                            k = drop_rows[tile_idx(c, r)].pop_front();
                            $display("%s: dropped at source (%0d,%0d)", rows[k].name, c, r);
                            n_drops++;
                            outstanding--;
                        end
                    end
                    // a busy target takes two lfsr bits and is ready a quarter of the time
                    if (stall_en[tile_idx(c, r)]) begin
                        b0 = lfsr[0];
                        lfsr = step_lfsr(lfsr);
                        b1 = lfsr[0];
                        lfsr = step_lfsr(lfsr);
                        tile_rsp_ready[c][r] <= b0 & b1;
                    end else begin
                        tile_rsp_ready[c][r] <= 1'b1;
                    end
                end
            end
        end
    end

    //====================
    // stimulus
    //====================
    initial begin
        t_tile_trans tr;
        int          s;
        int          t;
        reset = 1'b1;
        tile_req_valid = '0;
        tile_req = '0;
        tile_rsp_ready = '1;
        // name, source col/row, target col/row, tag, stall, lone, drop
        add_row("lone_self_22", 2, 2, 2, 2, 8'h01, 0, 1, 0);
        add_row("lone_11_33", 1, 1, 3, 3, 8'h02, 0, 1, 0);
        add_row("lone_31_13", 3, 1, 1, 3, 8'h03, 0, 1, 0);
        add_row("lone_23_21", 2, 3, 2, 1, 8'h04, 0, 1, 0);
        add_row("lone_12_32", 1, 2, 3, 2, 8'h05, 0, 1, 0);
        add_row("route_33_11", 3, 3, 1, 1, 8'h10, 0, 0, 0);
        add_row("route_21_12", 2, 1, 1, 2, 8'h11, 0, 0, 0);
        add_row("route_32_23", 3, 2, 2, 3, 8'h12, 0, 0, 0);
        add_row("route_13_31", 1, 3, 3, 1, 8'h13, 0, 0, 0);
        add_row("contend_21_33", 2, 1, 3, 3, 8'h20, 0, 0, 0);
        add_row("contend_13_33", 1, 3, 3, 3, 8'h21, 0, 0, 0);
        for (int i = 0; i < 4; i++) add_row($sformatf("order_12_33_%0d", i), 1, 2, 3, 3,
                                            8'h40 + 8'(i), 0, 0, 0);
        add_row("drop_col0", 2, 2, 0, 2, 8'h60, 0, 0, 1);
        add_row("drop_col4", 1, 1, 4, 1, 8'h61, 0, 0, 1);
        add_row("drop_row0", 3, 3, 2, 0, 8'h62, 0, 0, 1);
        add_row("drop_row4", 2, 1, 1, 4, 8'h63, 0, 0, 1);
        // more requests than the ten queue slots on the path, so the source must stall
        for (int i = 0; i < 20; i++) add_row($sformatf("bp_11_33_%0d", i), 1, 1, 3, 3,
                                             8'h80 + 8'(i), 1, 0, 0);
        for (int i = 0; i < 3; i++) add_row($sformatf("bp_22_33_%0d", i), 2, 2, 3, 3,
                                            8'hb0 + 8'(i), 1, 0, 0);

        // reset state checked once the first edge has cleared the flops
        @(posedge clk);
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 3) reset <= 1'b0;
            check_bits("reset rsp_valid", '0, tile_rsp_valid);
            check_bits("reset drop", '0, tile_drop);
            check_bits("reset req_ready", '1, tile_req_ready);
        end

        foreach (rows[i]) begin
            if (rows[i].lone) begin
                tile_req_valid <= '0;
                wait (outstanding == 0);
            end
            s = tile_idx(rows[i].sc, rows[i].sr);
            tr.target.col = 4'(rows[i].tc);
            tr.target.row = 4'(rows[i].tr);
            tr.source.col = 4'(rows[i].sc);
            tr.source.row = 4'(rows[i].sr);
            tr.tag = rows[i].tag;
            tr.data = rows[i].data;
            if (rows[i].stall) stall_en[tile_idx(rows[i].tc, rows[i].tr)] <= 1'b1;
            tile_req_valid <= '0;
            tile_req_valid[rows[i].sc][rows[i].sr] <= 1'b1;
            tile_req[rows[i].sc][rows[i].sr] <= tr;
            do @(posedge clk); while (!tile_req_ready[rows[i].sc][rows[i].sr]);
            outstanding++;  // handshake on this edge
            if (rows[i].drop) begin
                drop_rows[s].push_back(i);
                exp_drops++;
            end else begin
                t = tile_idx(rows[i].tc, rows[i].tr);
                exp_q[s][t].push_back(tr);
                exp_row[s][t].push_back(i);
                exp_t[s][t].push_back($time);
                exp_deliv++;
            end
            if (rows[i].lone) begin
                tile_req_valid <= '0;
                wait (outstanding == 0);
            end
        end
        tile_req_valid <= '0;
        foreach (stall_en[i]) stall_en[i] <= 1'b0;  // ready returns and the queues drain
        wait (outstanding == 0);
        repeat (10) @(posedge clk);

        check_count("deliveries", exp_deliv, n_deliv);
        check_count("drops", exp_drops, n_drops);
        check_count("backpressure seen", 1, saw_bp);
        $display("tests %0d, delivered %0d, dropped %0d, errors %0d",
                 rows.size(), n_deliv, n_drops, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog allows 200 cycles per row plus 500
    initial begin
        #1;
        #((200 * rows.size() + 500) * 100);
        $display("timeout: requests still outstanding %0d", outstanding);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/fabric_pkg.sv
rtl/fabric_fifo.sv
rtl/fabric_rr_arb.sv
rtl/big_core_tile.sv
rtl/fabric_big_cores.sv
dv/fabric_big_cores_assert.sv
dv/fabric_big_cores_tb.sv

// File: Bender.yml
package:
  name: fabric_big_cores

sources:
  # rtl in compile order
  - rtl/fabric_pkg.sv
  - rtl/fabric_fifo.sv
  - rtl/fabric_rr_arb.sv
  - rtl/big_core_tile.sv
  - rtl/fabric_big_cores.sv
  # verification
  - target: simulation
    files:
      - dv/fabric_big_cores_assert.sv
      - dv/fabric_big_cores_tb.sv
